/* axi_delayer_macros.svh */
// Numeric settings of the AXI delay shim, included by the package and by the RTL that needs them
`ifndef AXI_DELAYER_MACROS_SVH
`define AXI_DELAYER_MACROS_SVH

// Bus widths
`define AXI_ID_WIDTH 4
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64

// Free-running timestamp width
`define TS_WIDTH 40

// Minimum latencies in cycles, counted from request acceptance
`define READ_LATENCY 20
`define WRITE_LATENCY 12

// Read throttle: beats passed, then cycles blocked
`define READ_BEATS_UP 4
`define READ_BEATS_DOWN 2

// Write throttle: beats passed, then cycles blocked
`define WRITE_BEATS_UP 2
`define WRITE_BEATS_DOWN 3

// Timestamp queue depth and outstanding write limit, power of two
`define MAX_OUTSTANDING 4

`endif

/* axi_delayer_pkg.sv */
// AXI channel payload structs and the timestamp type shared by the delay shim and its testbench
`include "axi_delayer_macros.svh"

package axi_delayer_pkg;

    typedef logic [`TS_WIDTH-1:0] ts_t;

    // Shared by AW and AR
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
        logic                       lock;
        logic [3:0]                 cache;
        logic [2:0]                 prot;
        logic [3:0]                 qos;
        logic [3:0]                 region;
    } ax_chan_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0]   data;
        logic [`AXI_DATA_WIDTH/8-1:0] strb;
        logic                         last;
    } w_chan_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        logic [1:0]               resp;
    } b_chan_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;
        logic                       last;
    } r_chan_t;

endpackage

/* timestamp_fifo.sv */
// Circular queue of request timestamps, head always visible, used by both delay paths
`timescale 1ns/10ps
`include "axi_delayer_macros.svh"

module timestamp_fifo (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 push,
    input  axi_delayer_pkg::ts_t push_ts,
    input  logic                 pop,
    output axi_delayer_pkg::ts_t head_ts,
    output logic                 empty,
    output logic                 full
);

    localparam int DEPTH = `MAX_OUTSTANDING;
    localparam int PTR_W = $clog2(DEPTH);

    axi_delayer_pkg::ts_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           do_push;
    logic           do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Write falls through while the queue is empty
    assign head_ts = empty ? push_ts : mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_ts;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Owners must block requests before the queue overflows
    a_no_push_full: assert property (
        @(posedge aclk) disable iff (!aresetn) full |-> !push
    );

    // Release logic may only retire entries that exist
    a_no_pop_empty: assert property (
        @(posedge aclk) disable iff (!aresetn) empty |-> !pop
    );

endmodule

/* beat_throttle.sv */
// On/off gate for a data channel: passes BEATS_UP beats, then blocks for BEATS_DOWN cycles
`timescale 1ns/10ps

module beat_throttle #(
    parameter int BEATS_UP   = 1,
    parameter int BEATS_DOWN = 0
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic beat,
    output logic open
);

    localparam int UP_W   = (BEATS_UP > 1) ? $clog2(BEATS_UP) : 1;
    localparam int DOWN_W = (BEATS_DOWN > 1) ? $clog2(BEATS_DOWN) : 1;

    localparam logic [UP_W-1:0]   UP_LAST   = UP_W'(BEATS_UP - 1);
    localparam logic [DOWN_W-1:0] DOWN_LAST = DOWN_W'(BEATS_DOWN - 1);

    logic [UP_W-1:0]   up_cnt;
    logic [DOWN_W-1:0] down_cnt;
    logic              closed;

    assign open = !closed;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            closed   <= 1'b0;
            up_cnt   <= '0;
            down_cnt <= '0;
        end else if (!closed) begin
            if (beat) begin
                if (up_cnt == UP_LAST) begin
                    up_cnt <= '0;
                    // A zero off time keeps the channel open forever
                    if (BEATS_DOWN != 0) begin
                        closed   <= 1'b1;
                        down_cnt <= '0;
                    end
                end else begin
                    up_cnt <= up_cnt + 1'b1;
                end
            end
        end else begin
            if (down_cnt == DOWN_LAST) begin
                closed <= 1'b0;
            end else begin
                down_cnt <= down_cnt + 1'b1;
            end
        end
    end

    // Owner gates valid and ready with open, so no beat lands in the off window
    a_no_beat_closed: assert property (
        @(posedge aclk) disable iff (!aresetn) beat |-> open
    );

endmodule

/* read_delay_path.sv */
// Read side of the delay shim: stamps AR acceptance and releases each R burst after its latency
`timescale 1ns/10ps
`include "axi_delayer_macros.svh"

module read_delay_path (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  axi_delayer_pkg::ts_t      ts_now,
    input  axi_delayer_pkg::ax_chan_t s_ar,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output axi_delayer_pkg::ax_chan_t m_ar,
    output logic                      m_arvalid,
    input  logic                      m_arready,
    input  axi_delayer_pkg::r_chan_t  m_r,
    input  logic                      m_rvalid,
    output logic                      m_rready,
    output axi_delayer_pkg::r_chan_t  s_r,
    output logic                      s_rvalid,
    input  logic                      s_rready
);

    localparam axi_delayer_pkg::ts_t LATENCY = `READ_LATENCY;

    typedef enum logic {
        r_idle,
        r_releasing
    } r_state_t;

    r_state_t             state;
    axi_delayer_pkg::ts_t head_ts;
    logic                 q_push;
    logic                 q_pop;
    logic                 q_empty;
    logic                 q_full;
    logic                 head_due;
    logic                 r_open;
    logic                 r_gate;
    logic                 r_xfer;

    // AR passes straight through unless the queue has no room
    assign m_ar      = s_ar;
    assign m_arvalid = s_arvalid && !q_full;
    assign s_arready = m_arready && !q_full;
    assign q_push    = s_arvalid && m_arready && !q_full;

    timestamp_fifo u_ar_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .push    (q_push),
        .push_ts (ts_now),
        .pop     (q_pop),
        .head_ts (head_ts),
        .empty   (q_empty),
        .full    (q_full)
    );

    // Subtraction keeps the age right across counter wrap
    assign head_due = !q_empty && ((ts_now - head_ts) >= LATENCY);
    assign q_pop    = (state == r_idle) && head_due;

    beat_throttle #(
        .BEATS_UP   (`READ_BEATS_UP),
        .BEATS_DOWN (`READ_BEATS_DOWN)
    ) u_r_throttle (
        .aclk    (aclk),
        .aresetn (aresetn),
        .beat    (r_xfer),
        .open    (r_open)
    );

    assign r_gate   = (state == r_releasing) && r_open;
    assign s_r      = m_r;
    assign s_rvalid = r_gate && m_rvalid;
    assign m_rready = r_gate && s_rready;
    assign r_xfer   = r_gate && m_rvalid && s_rready;

    // One burst at a time, ended by the rlast transfer
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= r_idle;
        end else begin
            case (state)
                r_idle: begin
                    if (head_due) begin
                        state <= r_releasing;
                    end
                end
                r_releasing: begin
                    if (r_xfer && m_r.last) begin
                        state <= r_idle;
                    end
                end
                default: state <= r_idle;
            endcase
        end
    end

endmodule

/* write_delay_path.sv */
// Write side of the delay shim: outstanding limit, throttled W and B held back by wlast age
`timescale 1ns/10ps
`include "axi_delayer_macros.svh"

module write_delay_path (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  axi_delayer_pkg::ts_t      ts_now,
    input  axi_delayer_pkg::ax_chan_t s_aw,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    output axi_delayer_pkg::ax_chan_t m_aw,
    output logic                      m_awvalid,
    input  logic                      m_awready,
    input  axi_delayer_pkg::w_chan_t  s_w,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output axi_delayer_pkg::w_chan_t  m_w,
    output logic                      m_wvalid,
    input  logic                      m_wready,
    input  axi_delayer_pkg::b_chan_t  m_b,
    input  logic                      m_bvalid,
    output logic                      m_bready,
    output axi_delayer_pkg::b_chan_t  s_b,
    output logic                      s_bvalid,
    input  logic                      s_bready
);

    localparam axi_delayer_pkg::ts_t LATENCY = `WRITE_LATENCY;
    localparam int                   OUT_W   = $clog2(`MAX_OUTSTANDING + 1);
    localparam logic [OUT_W-1:0]     OUT_MAX = OUT_W'(`MAX_OUTSTANDING);

    typedef enum logic {
        b_idle,
        b_issuing
    } b_state_t;

    b_state_t             state;
    axi_delayer_pkg::ts_t head_ts;
    logic [OUT_W-1:0]     outstanding;
    logic                 at_limit;
    logic                 aw_xfer;
    logic                 w_open;
    logic                 w_gate;
    logic                 w_xfer;
    logic                 b_gate;
    logic                 b_xfer;
    logic                 q_push;
    logic                 q_pop;
    logic                 q_empty;
    logic                 q_full;
    logic                 head_due;

    // AW blocked once the limit of unanswered writes is reached
    assign at_limit  = (outstanding == OUT_MAX);
    assign m_aw      = s_aw;
    assign m_awvalid = s_awvalid && !at_limit;
    assign s_awready = m_awready && !at_limit;
    assign aw_xfer   = s_awvalid && m_awready && !at_limit;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            outstanding <= '0;
        end else if (aw_xfer && !b_xfer) begin
            outstanding <= outstanding + 1'b1;
        end else if (!aw_xfer && b_xfer) begin
            outstanding <= outstanding - 1'b1;
        end
    end

    beat_throttle #(
        .BEATS_UP   (`WRITE_BEATS_UP),
        .BEATS_DOWN (`WRITE_BEATS_DOWN)
    ) u_w_throttle (
        .aclk    (aclk),
        .aresetn (aresetn),
        .beat    (w_xfer),
        .open    (w_open)
    );

    // W also waits for queue room, since data may run ahead of AW
    assign w_gate   = w_open && !q_full;
    assign m_w      = s_w;
    assign m_wvalid = w_gate && s_wvalid;
    assign s_wready = w_gate && m_wready;
    assign w_xfer   = w_gate && s_wvalid && m_wready;
    assign q_push   = w_xfer && s_w.last;

    timestamp_fifo u_w_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .push    (q_push),
        .push_ts (ts_now),
        .pop     (q_pop),
        .head_ts (head_ts),
        .empty   (q_empty),
        .full    (q_full)
    );

    assign head_due = !q_empty && ((ts_now - head_ts) >= LATENCY);

    assign b_gate   = (state == b_issuing);
    assign s_b      = m_b;
    assign s_bvalid = b_gate && m_bvalid;
    assign m_bready = b_gate && s_bready;
    assign b_xfer   = b_gate && m_bvalid && s_bready;
    assign q_pop    = b_xfer;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= b_idle;
        end else begin
            case (state)
                b_idle: begin
                    if (head_due) begin
                        state <= b_issuing;
                    end
                end
                b_issuing: begin
                    if (b_xfer) begin
                        state <= b_idle;
                    end
                end
                default: state <= b_idle;
            endcase
        end
    end

    // Counter and AW blocking together keep the limit
    a_outstanding_max: assert property (
        @(posedge aclk) disable iff (!aresetn) outstanding <= OUT_MAX
    );

endmodule

/* axi_delayer.sv */
// Top level of the AXI4 delay shim: timestamp counter plus the read and write delay paths
`timescale 1ns/10ps

module axi_delayer (
    input  logic                      aclk,
    input  logic                      aresetn,
    // Manager side
    input  axi_delayer_pkg::ax_chan_t s_aw,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  axi_delayer_pkg::w_chan_t  s_w,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output axi_delayer_pkg::b_chan_t  s_b,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  axi_delayer_pkg::ax_chan_t s_ar,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output axi_delayer_pkg::r_chan_t  s_r,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    // Subordinate side
    output axi_delayer_pkg::ax_chan_t m_aw,
    output logic                      m_awvalid,
    input  logic                      m_awready,
    output axi_delayer_pkg::w_chan_t  m_w,
    output logic                      m_wvalid,
    input  logic                      m_wready,
    input  axi_delayer_pkg::b_chan_t  m_b,
    input  logic                      m_bvalid,
    output logic                      m_bready,
    output axi_delayer_pkg::ax_chan_t m_ar,
    output logic                      m_arvalid,
    input  logic                      m_arready,
    input  axi_delayer_pkg::r_chan_t  m_r,
    input  logic                      m_rvalid,
    output logic                      m_rready
);

    axi_delayer_pkg::ts_t ts_now;

    // Time base for both latency checks
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ts_now <= '0;
        end else begin
            ts_now <= ts_now + 1'b1;
        end
    end

    read_delay_path u_read (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ts_now    (ts_now),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    write_delay_path u_write (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ts_now    (ts_now),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_b       (m_b),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready)
    );

endmodule

/* tb_axi_delayer.sv */
// Self-checking testbench for the AXI delay shim; drives both bus sides and checks every transfer
`timescale 1ns/10ps
`include "axi_delayer_macros.svh"

module tb_axi_delayer;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DLY      = 1;
    localparam int RNG_SEED       = 81157;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int N_READS        = 24;
    localparam int N_WRITES       = 24;

    localparam int CH_AR = 0;
    localparam int CH_AW = 1;
    localparam int CH_W  = 2;
    localparam int CH_R  = 3;
    localparam int CH_B  = 4;

    localparam int WAIT_DRAIN    = 0;
    localparam int WAIT_AT_LIMIT = 1;
    localparam int WAIT_AW_DONE  = 2;

    // Expected response fields and the earliest cycle it may be seen
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        logic                     last;
        logic [63:0]              earliest;
    } expect_t;

    logic                      aclk = 1'b0;
    logic                      aresetn;
    axi_delayer_pkg::ax_chan_t s_aw;
    logic                      s_awvalid;
    logic                      s_awready;
    axi_delayer_pkg::w_chan_t  s_w;
    logic                      s_wvalid;
    logic                      s_wready;
    axi_delayer_pkg::b_chan_t  s_b;
    logic                      s_bvalid;
    logic                      s_bready;
    axi_delayer_pkg::ax_chan_t s_ar;
    logic                      s_arvalid;
    logic                      s_arready;
    axi_delayer_pkg::r_chan_t  s_r;
    logic                      s_rvalid;
    logic                      s_rready;
    axi_delayer_pkg::ax_chan_t m_aw;
    logic                      m_awvalid;
    logic                      m_awready;
    axi_delayer_pkg::w_chan_t  m_w;
    logic                      m_wvalid;
    logic                      m_wready;
    axi_delayer_pkg::b_chan_t  m_b;
    logic                      m_bvalid;
    logic                      m_bready;
    axi_delayer_pkg::ax_chan_t m_ar;
    logic                      m_arvalid;
    logic                      m_arready;
    axi_delayer_pkg::r_chan_t  m_r;
    logic                      m_rvalid;
    logic                      m_rready;

    // Bookkeeping shared by the comparing process, the subordinate model and the main flow
    axi_delayer_pkg::ax_chan_t ar_rec[$];
    logic [63:0]               ar_cyc[$];
    axi_delayer_pkg::ax_chan_t rd_jobs[$];
    axi_delayer_pkg::ax_chan_t wr_aw[$];
    logic [63:0]               wlast_cyc[$];
    logic [`AXI_ID_WIDTH-1:0]  m_aw_ids[$];
    logic [`AXI_ID_WIDTH-1:0]  b_jobs[$];
    axi_delayer_pkg::ax_chan_t cur_ar;
    logic [63:0]               cur_ar_cyc;
    expect_t                   exp_rsp;
    logic [63:0]               cycle = '0;
    logic [63:0]               r_off_until = '0;
    logic [63:0]               w_off_until = '0;
    int                        r_beat = 0;
    int                        r_total = 0;
    int                        w_total = 0;
    int                        unmatched_wlast = 0;
    int                        ar_count = 0;
    int                        r_bursts = 0;
    int                        aw_count = 0;
    int                        b_count = 0;
    int                        aw_target = 0;
    logic                      hold_b = 1'b0;
    logic                      ready_toggle_on = 1'b0;

    axi_delayer u_dut (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic fail_run(input string msg);
        $display("%0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // First beat of a burst may pass READ_LATENCY+1 cycles after its AR at the earliest
    function automatic expect_t ref_read(input axi_delayer_pkg::ax_chan_t ar,
                                         input logic [63:0] ar_cycle, input int beat);
        expect_t e;
        e.id       = ar.id;
        e.last     = (beat == int'(ar.len));
        e.earliest = (beat == 0) ? ar_cycle + `READ_LATENCY + 1 : 64'd0;
        return e;
    endfunction

    // B may pass WRITE_LATENCY+1 cycles after the wlast of its write at the earliest
    function automatic expect_t ref_write(input axi_delayer_pkg::ax_chan_t aw,
                                          input logic [63:0] wlast_cycle);
        expect_t e;
        e.id       = aw.id;
        e.last     = 1'b1;
        e.earliest = wlast_cycle + `WRITE_LATENCY + 1;
        return e;
    endfunction

    function automatic axi_delayer_pkg::ax_chan_t make_ax();
        axi_delayer_pkg::ax_chan_t ax;
        ax        = '0;
        ax.id     = 4'($urandom);
        ax.addr   = $urandom;
        ax.len    = 8'($urandom % 8);
        ax.size   = 3'd3;
        ax.burst  = 2'd1;
        ax.cache  = 4'($urandom);
        ax.prot   = 3'($urandom);
        ax.qos    = 4'($urandom);
        return ax;
    endfunction

    function automatic logic handshake_ready(input int chan);
        case (chan)
            CH_AR:   return s_arready;
            CH_AW:   return s_awready;
            CH_W:    return s_wready;
            CH_R:    return m_rready;
            CH_B:    return m_bready;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic condition_met(input int what);
        case (what)
            WAIT_DRAIN:    return (b_count == aw_count) && (r_bursts == ar_count);
            WAIT_AT_LIMIT: return ((aw_count - b_count) == `MAX_OUTSTANDING) && s_awvalid;
            WAIT_AW_DONE:  return aw_count >= aw_target;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #DRIVE_DLY;
        end
    endtask

    // Entered just after a drive, left just after the accepting edge
    task automatic wait_accept(input int chan, input string what);
        int waited;
        waited = 0;
        @(posedge aclk);
        while (!handshake_ready(chan)) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_run({"no handshake on ", what, " before the timeout"});
            end
            @(posedge aclk);
        end
        #DRIVE_DLY;
    endtask

    task automatic wait_for(input int what, input string desc);
        int waited;
        waited = 0;
        @(negedge aclk);
        while (!condition_met(what)) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_run({"timed out waiting for ", desc});
            end
            @(negedge aclk);
        end
    endtask

    task automatic run_reads(input int n);
        idle_cycles(1);
        for (int i = 0; i < n; i++) begin
            idle_cycles($urandom % 3);
            s_ar      = make_ax();
            s_arvalid = 1'b1;
            wait_accept(CH_AR, "AR");
            s_arvalid = 1'b0;
        end
    endtask

    task automatic run_writes(input int n);
        axi_delayer_pkg::ax_chan_t aws[$];
        for (int i = 0; i < n; i++) begin
            aws.push_back(make_ax());
        end
        fork
            begin
                idle_cycles(1);
                for (int i = 0; i < n; i++) begin
                    idle_cycles($urandom % 3);
                    s_aw      = aws[i];
                    s_awvalid = 1'b1;
                    wait_accept(CH_AW, "AW");
                    s_awvalid = 1'b0;
                end
            end
            begin
                idle_cycles(1);
                for (int i = 0; i < n; i++) begin
                    for (int beat = 0; beat <= int'(aws[i].len); beat++) begin
                        idle_cycles(($urandom % 4 == 0) ? 1 : 0);
                        s_w = '{data: {$urandom, $urandom}, strb: 8'($urandom),
                                last: (beat == int'(aws[i].len))};
                        s_wvalid = 1'b1;
                        wait_accept(CH_W, "W");
                        s_wvalid = 1'b0;
                    end
                end
            end
        join
    endtask

    // Both sides drop ready now and then
    always begin : ready_toggle
        @(posedge aclk);
        #DRIVE_DLY;
        if (ready_toggle_on) begin
            m_arready = ($urandom % 4) != 0;
            m_awready = ($urandom % 4) != 0;
            m_wready  = ($urandom % 4) != 0;
            s_rready  = ($urandom % 4) != 0;
            s_bready  = ($urandom % 4) != 0;
        end
    end

    always begin : r_responder
        axi_delayer_pkg::ax_chan_t job;
        @(posedge aclk);
        #DRIVE_DLY;
        if (rd_jobs.size() != 0) begin
            job = rd_jobs.pop_front();
            for (int beat = 0; beat <= int'(job.len); beat++) begin
                idle_cycles(($urandom % 4 == 0) ? 1 : 0);
                m_r = '{id: job.id, data: {$urandom, $urandom}, resp: 2'($urandom),
                        last: (beat == int'(job.len))};
                m_rvalid = 1'b1;
                wait_accept(CH_R, "R on the subordinate side");
                m_rvalid = 1'b0;
            end
        end
    end

    always begin : b_responder
        logic [`AXI_ID_WIDTH-1:0] b_id;
        @(posedge aclk);
        #DRIVE_DLY;
        if (!hold_b && b_jobs.size() != 0) begin
            b_id = b_jobs.pop_front();
            idle_cycles(($urandom % 4 == 0) ? 1 : 0);
            m_b      = '{id: b_id, resp: 2'($urandom)};
            m_bvalid = 1'b1;
            wait_accept(CH_B, "B on the subordinate side");
            m_bvalid = 1'b0;
        end
    end

    // Comparing process, samples every channel on the rising edge
    always @(posedge aclk) begin : compare_proc
        cycle = cycle + 1;
        if (aresetn) begin
            check_value("m_arvalid && m_arready", m_arvalid && m_arready, s_arvalid && s_arready);
            if (s_arvalid && s_arready) begin
                check_value("m_ar", m_ar, s_ar);
                ar_rec.push_back(s_ar);
                ar_cyc.push_back(cycle);
                rd_jobs.push_back(m_ar);
                ar_count++;
            end
            check_value("m_awvalid && m_awready", m_awvalid && m_awready, s_awvalid && s_awready);
            if (s_awvalid && s_awready) begin
                check_value("m_aw", m_aw, s_aw);
                wr_aw.push_back(s_aw);
                m_aw_ids.push_back(m_aw.id);
                aw_count++;
            end
            check_value("m_wvalid && m_wready", m_wvalid && m_wready, s_wvalid && s_wready);
            if (s_wvalid && s_wready) begin
                check_value("m_w", m_w, s_w);
                check_value("s_wvalid in throttle off window", cycle <= w_off_until, 1'b0);
                w_total++;
                if (w_total % `WRITE_BEATS_UP == 0) begin
                    w_off_until = cycle + `WRITE_BEATS_DOWN;
                end
                if (s_w.last) begin
                    wlast_cyc.push_back(cycle);
                    unmatched_wlast++;
                end
            end
            // A subordinate answers a write once both its AW and its last beat arrived
            while (m_aw_ids.size() != 0 && unmatched_wlast != 0) begin
                b_jobs.push_back(m_aw_ids.pop_front());
                unmatched_wlast--;
            end
            check_value("s_bvalid && s_bready", s_bvalid && s_bready, m_bvalid && m_bready);
            if (s_bvalid && s_bready) begin
                check_value("s_b", s_b, m_b);
                if (wr_aw.size() == 0 || wlast_cyc.size() == 0) begin
                    fail_run("a B transfer passed with no completed write pending");
                end
                exp_rsp = ref_write(wr_aw.pop_front(), wlast_cyc.pop_front());
                check_value("s_b.id", s_b.id, exp_rsp.id);
                check_value("s_bvalid before write latency", cycle < exp_rsp.earliest, 1'b0);
                b_count++;
            end
            check_value("s_rvalid && s_rready", s_rvalid && s_rready, m_rvalid && m_rready);
            if (s_rvalid && s_rready) begin
                check_value("s_r", s_r, m_r);
                if (r_beat == 0) begin
                    if (ar_rec.size() == 0) begin
                        fail_run("an R beat passed with no AR pending");
                    end
                    cur_ar     = ar_rec.pop_front();
                    cur_ar_cyc = ar_cyc.pop_front();
                end
                exp_rsp = ref_read(cur_ar, cur_ar_cyc, r_beat);
                check_value("s_r.id", s_r.id, exp_rsp.id);
                check_value("s_r.last", s_r.last, exp_rsp.last);
                check_value("s_rvalid before read latency", cycle < exp_rsp.earliest, 1'b0);
                check_value("s_rvalid in throttle off window", cycle <= r_off_until, 1'b0);
                r_total++;
                if (r_total % `READ_BEATS_UP == 0) begin
                    r_off_until = cycle + `READ_BEATS_DOWN;
                end
                if (s_r.last) begin
                    r_beat = 0;
                    r_bursts++;
                end else begin
                    r_beat++;
                end
            end
        end
    end

    initial begin : main_flow
        aresetn   = 1'b0;
        s_aw      = '0;
        s_awvalid = 1'b0;
        s_w       = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        s_ar      = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_b       = '0;
        m_bvalid  = 1'b0;
        m_arready = 1'b0;
        m_r       = '0;
        m_rvalid  = 1'b0;
        void'($urandom(RNG_SEED));

        repeat (10) @(posedge aclk);
        #DRIVE_DLY;
        aresetn = 1'b1;
        // Subordinate valids and manager readies high, so only the gates hold these low
        m_rvalid = 1'b1;
        m_bvalid = 1'b1;
        @(negedge aclk);
        check_value("s_rvalid", s_rvalid, 1'b0);
        check_value("s_bvalid", s_bvalid, 1'b0);
        check_value("m_rready", m_rready, 1'b0);
        check_value("m_bready", m_bready, 1'b0);
        m_rvalid        = 1'b0;
        m_bvalid        = 1'b0;
        ready_toggle_on = 1'b1;

        // Mixed traffic on both paths
        fork
            run_reads(N_READS);
            run_writes(N_WRITES);
        join
        wait_for(WAIT_DRAIN, "all responses after mixed traffic");

        // Withhold B and push one write past the limit
        @(negedge aclk);
        hold_b    = 1'b1;
        aw_target = aw_count + `MAX_OUTSTANDING + 1;
        fork
            run_writes(`MAX_OUTSTANDING + 1);
        join_none
        wait_for(WAIT_AT_LIMIT, "the outstanding write limit");
        repeat (20) begin
            @(negedge aclk);
            check_value("s_awvalid", s_awvalid, 1'b1);
            check_value("s_awready", s_awready, 1'b0);
        end
        hold_b = 1'b0;
        wait_for(WAIT_AW_DONE, "AW acceptance after a B was given");
        wait_for(WAIT_DRAIN, "all responses after the limit test");

        repeat (5) @(posedge aclk);
        $display("sim passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
axi_delayer_pkg.sv
timestamp_fifo.sv
beat_throttle.sv
read_delay_path.sv
write_delay_path.sv
axi_delayer.sv
tb_axi_delayer.sv

/* Bender.yml */
package:
  name: axi_delayer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axi_delayer_pkg.sv
      - timestamp_fifo.sv
      - beat_throttle.sv
      - read_delay_path.sv
      - write_delay_path.sv
      - axi_delayer.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_axi_delayer.sv
